// ==== flist.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_req_decode.sv
hdl/csr_regfile.sv
hdl/csr_rsp_buffer.sv
hdl/csr_unit.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := csr_unit_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/csr_unit_tb.sv ====
`include "csr_cfg.svh"

module csr_unit_tb;
  import csr_pkg::*;

  localparam int MAX_CYCLES = 20000; // ~410 requests, worst case a few dozen cycles each
  localparam int NREG       = 10;
  localparam int I_CRMD     = 0;
  localparam int I_PRMD     = 1;
  localparam int I_ESTAT    = 2;
  localparam int I_ERA      = 3;
  localparam int I_EENTRY   = 4;
  localparam int I_TID      = 9;

  localparam csr_addr_t REG_ADDR [NREG] = '{
    `CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY,
    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID
  };
  // Bits that software may change in each register
  localparam csr_data_t WR_LIMIT [NREG] = '{
    32'h0000_01ff, 32'h0000_0007, 32'h0000_0003, 32'hffff_ffff, 32'hffff_ffc0,
    32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff
  };

  logic      clk;
  logic      rst_n;
  logic      req_valid_i;
  logic      req_ready_o;
  csr_addr_t req_addr_i;
  rdcnt_t    req_cnt_i;
  csr_data_t req_mask_i;
  csr_data_t req_wdata_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i = 1'b1;
  csr_data_t rsp_data_o;
  logic      excp_valid_i;
  csr_data_t excp_pc_i;
  ecode_t    excp_ecode_i;
  logic      ertn_i;
  csr_data_t crmd_o;
  csr_data_t era_o;
  csr_data_t eentry_o;

  // Reference model and expected responses
  csr_data_t m_reg [NREG];
  csr_data_t exp_data [$];
  bit        exp_vlow [$];
  logic      head_valid = 1'b0;
  csr_data_t head_data  = '0;
  logic      head_vlow  = 1'b0;
  csr_data_t last_vlow  = '0;
  int        pend_cnt   = 0;
  csr_data_t st_crmd    = '0;
  csr_data_t st_era     = '0;
  csr_data_t st_eentry  = '0;
  int        cycles     = 0;
  int        full_hits  = 0;
  logic      bp_on      = 1'b0;

  csr_unit uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic int reg_index(input csr_addr_t addr);
    for (int i = 0; i < NREG; i++) begin
      if (REG_ADDR[i] == addr) return i;
    end
    return -1;
  endfunction

  function automatic csr_addr_t unknown_addr();
    csr_data_t r;
    csr_addr_t a;
    r = $urandom();
    a = r[13:0];
    while (reg_index(a) >= 0) a = a + 14'd1; // Step past mapped CSRs
    return a;
  endfunction

  task automatic model_access(input csr_addr_t addr, input rdcnt_t cnt,
                              input csr_data_t mask, input csr_data_t wdata);
    int        idx;
    csr_data_t old_v;
    csr_data_t wm;
    idx   = reg_index(addr);
    old_v = '0;
    if (cnt == `RDCNT_ID) begin
      old_v = m_reg[I_TID];
    end else if (cnt == `RDCNT_NONE && idx >= 0) begin
      old_v      = m_reg[idx];
      wm         = mask & WR_LIMIT[idx];
      m_reg[idx] = (old_v & ~wm) | (wdata & wm);
    end
    exp_data.push_back(old_v); // VHIGH stays zero this early
    exp_vlow.push_back(cnt == `RDCNT_VLOW);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREG; i++) m_reg[i] = '0;
      m_reg[I_CRMD] = 32'h8; // DA
      exp_data.delete();
      exp_vlow.delete();
      last_vlow <= '0;
    end else begin
      if (rsp_valid_o && rsp_ready_i && exp_data.size() > 0) begin
        if (exp_vlow[0]) last_vlow <= rsp_data_o;
        void'(exp_data.pop_front());
        void'(exp_vlow.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        model_access(req_addr_i, req_cnt_i, req_mask_i, req_wdata_i);
      end
      if (excp_valid_i) begin
        m_reg[I_PRMD][`PRMD_PPLV]    = m_reg[I_CRMD][`CRMD_PLV];
        m_reg[I_PRMD][`PRMD_PIE]     = m_reg[I_CRMD][`CRMD_IE];
        m_reg[I_CRMD][`CRMD_PLV]     = 2'b00;
        m_reg[I_CRMD][`CRMD_IE]      = 1'b0;
        m_reg[I_ERA]                 = excp_pc_i;
        m_reg[I_ESTAT][`ESTAT_ECODE] = excp_ecode_i;
      end
      if (ertn_i) begin
        m_reg[I_CRMD][`CRMD_PLV] = m_reg[I_PRMD][`PRMD_PPLV];
        m_reg[I_CRMD][`CRMD_IE]  = m_reg[I_PRMD][`PRMD_PIE];
      end
      if (pend_cnt == 3) full_hits++;
    end
    head_valid <= exp_data.size() > 0;
    head_data  <= (exp_data.size() > 0) ? exp_data[0] : '0;
    head_vlow  <= (exp_vlow.size() > 0) ? exp_vlow[0] : 1'b0;
    pend_cnt   <= exp_data.size();
    st_crmd    <= m_reg[I_CRMD];
    st_era     <= m_reg[I_ERA];
    st_eentry  <= m_reg[I_EENTRY];
  end

  always @(posedge clk) begin
    logic [31:0] r;
    r = $urandom();
    if (bp_on) begin
      rsp_ready_i <= (r[1:0] == 2'b00); // Mostly stalled
    end else begin
      rsp_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) stop_run("Timeout: the run did not finish within the cycle limit");
  end

  a_rsp_match: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && rsp_ready_i |->
      head_valid && (head_vlow ? (rsp_data_o > last_vlow) : (rsp_data_o == head_data)))
    else stop_run($sformatf("Fail %0t: response %h, expected %h (counter low %0b)", $time,
                            $sampled(rsp_data_o), $sampled(head_data), $sampled(head_vlow)));

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
    else stop_run($sformatf("Fail %0t: response changed while waiting", $time));

  a_reset_state: assert property (@(posedge clk) !rst_n |=> !rsp_valid_o && req_ready_o)
    else stop_run($sformatf("Fail %0t: handshake outputs wrong after reset", $time));

  a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
    pend_cnt == 3 |-> !req_ready_o)
    else stop_run($sformatf("Fail %0t: request accepted with three pending", $time));

  a_pend_bound: assert property (@(posedge clk) disable iff (!rst_n) pend_cnt <= 3)
    else stop_run($sformatf("Fail %0t: %0d requests in flight", $time, $sampled(pend_cnt)));

  // Status outputs only compared once the pipeline is idle
  a_status: assert property (@(posedge clk) disable iff (!rst_n)
    pend_cnt == 0 |-> crmd_o == st_crmd && era_o == st_era && eentry_o == st_eentry)
    else stop_run($sformatf("Fail %0t: crmd %h era %h eentry %h, expected %h %h %h", $time,
                            $sampled(crmd_o), $sampled(era_o), $sampled(eentry_o),
                            $sampled(st_crmd), $sampled(st_era), $sampled(st_eentry)));

  task automatic send_req(input csr_addr_t addr, input rdcnt_t cnt,
                          input csr_data_t mask, input csr_data_t wdata);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_cnt_i   <= cnt;
    req_mask_i  <= mask;
    req_wdata_i <= wdata;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
  endtask

  task automatic send_random(input bit with_cnt);
    csr_data_t r;
    csr_data_t mask;
    csr_addr_t addr;
    rdcnt_t    cnt;
    int        k;
    r    = $urandom();
    k    = int'(r[7:4]) % (NREG + 1);
    addr = (k == NREG) ? unknown_addr() : REG_ADDR[k];
    cnt  = (with_cnt && r[1:0] == 2'b00) ? r[3:2] : `RDCNT_NONE;
    case (r[9:8])
      2'd0:    mask = '0;
      2'd1:    mask = '1;
      default: mask = $urandom();
    endcase
    send_req(addr, cnt, mask, $urandom());
  endtask

  task automatic read_all();
    for (int i = 0; i < NREG; i++) send_req(REG_ADDR[i], `RDCNT_NONE, '0, $urandom());
  endtask

  task automatic drain();
    req_valid_i <= 1'b0;
    bp_on       <= 1'b0;
    @(posedge clk);
    while (pend_cnt != 0) @(posedge clk);
  endtask

  initial begin
    csr_data_t r;
    void'($urandom(32'h705));
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_cnt_i    = `RDCNT_NONE;
    req_mask_i   = '0;
    req_wdata_i  = '0;
    excp_valid_i = 1'b0;
    excp_pc_i    = '0;
    excp_ecode_i = '0;
    ertn_i       = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    read_all();
    repeat (200) send_random(1'b0);
    read_all();
    send_req(`CSR_CRMD, `RDCNT_NONE, 32'h7, 32'h7); // PLV 3, IE set
    drain();

    r = $urandom();
    excp_valid_i <= 1'b1;
    excp_pc_i    <= $urandom();
    excp_ecode_i <= r[5:0];
    @(posedge clk);
    excp_valid_i <= 1'b0;
    read_all();
    send_req(`CSR_PRMD, `RDCNT_NONE, '1, $urandom());
    drain();

    ertn_i <= 1'b1;
    @(posedge clk);
    ertn_i <= 1'b0;
    read_all();
    drain();

    bp_on <= 1'b1;
    repeat (150) send_random(1'b1);
    drain();

    // Address and mask are ignored on counter reads
    repeat (8) send_req(`CSR_SAVE0, `RDCNT_VLOW, '1, $urandom());
    send_req(`CSR_TID, `RDCNT_VHIGH, '1, $urandom());
    send_req(`CSR_ERA, `RDCNT_ID, '1, $urandom());
    read_all();
    drain();

    if (full_hits == 0) begin
      stop_run("Back-pressure never filled the pipeline with three requests");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== hdl/csr_unit.sv ====
module csr_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  csr_pkg::csr_addr_t req_addr_i,
  input  csr_pkg::rdcnt_t    req_cnt_i,
  input  csr_pkg::csr_data_t req_mask_i,
  input  csr_pkg::csr_data_t req_wdata_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output csr_pkg::csr_data_t rsp_data_o,
  input  logic               excp_valid_i,
  input  csr_pkg::csr_data_t excp_pc_i,
  input  csr_pkg::ecode_t    excp_ecode_i,
  input  logic               ertn_i,
  output csr_pkg::csr_data_t crmd_o,
  output csr_pkg::csr_data_t era_o,
  output csr_pkg::csr_data_t eentry_o
);
  import csr_pkg::*;

  // Decode to register file
  logic      acc_valid;
  logic      acc_ready;
  csr_sel_t  acc_sel;
  rdcnt_t    acc_cnt;
  csr_data_t acc_mask;
  csr_data_t acc_wdata;

  // Register file to response FIFO
  logic      push_valid;
  logic      push_ready;
  csr_data_t push_data;

  csr_req_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_cnt_i   (req_cnt_i),
    .req_mask_i  (req_mask_i),
    .req_wdata_i (req_wdata_i),
    .acc_valid_o (acc_valid),
    .acc_ready_i (acc_ready),
    .acc_sel_o   (acc_sel),
    .acc_cnt_o   (acc_cnt),
    .acc_mask_o  (acc_mask),
    .acc_wdata_o (acc_wdata)
  );

  csr_regfile u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_valid_i  (acc_valid),
    .acc_ready_o  (acc_ready),
    .acc_sel_i    (acc_sel),
    .acc_cnt_i    (acc_cnt),
    .acc_mask_i   (acc_mask),
    .acc_wdata_i  (acc_wdata),
    .push_valid_o (push_valid),
    .push_ready_i (push_ready),
    .push_data_o  (push_data),
    .excp_valid_i (excp_valid_i),
    .excp_pc_i    (excp_pc_i),
    .excp_ecode_i (excp_ecode_i),
    .ertn_i       (ertn_i),
    .crmd_o       (crmd_o),
    .era_o        (era_o),
    .eentry_o     (eentry_o)
  );

  csr_rsp_buffer u_rsp_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_data_i  (push_data),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_data_o   (rsp_data_o)
  );

endmodule

// ==== hdl/csr_rsp_buffer.sv ====
`include "csr_cfg.svh"

module csr_rsp_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push_valid_i,
  output logic               push_ready_o,
  input  csr_pkg::csr_data_t push_data_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output csr_pkg::csr_data_t rsp_data_o
);
  import csr_pkg::*;

  localparam int PTR_W = (`RSP_DEPTH > 1) ? $clog2(`RSP_DEPTH) : 1;
  localparam int CNT_W = $clog2(`RSP_DEPTH + 1);

  csr_data_t        mem [`RSP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`RSP_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push_ready_o = (count != CNT_W'(`RSP_DEPTH));
  assign rsp_valid_o  = (count != '0);
  assign rsp_data_o   = mem[rd_ptr]; // Oldest entry
  assign push         = push_valid_i && push_ready_o;
  assign pop          = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Write pointer leads read pointer by count
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(`RSP_DEPTH) &&
      int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % `RSP_DEPTH
  );

  a_rsp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o)
  );

endmodule

// ==== hdl/csr_regfile.sv ====
`include "csr_cfg.svh"

module csr_regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               acc_valid_i,
  output logic               acc_ready_o,
  input  csr_pkg::csr_sel_t  acc_sel_i,
  input  csr_pkg::rdcnt_t    acc_cnt_i,
  input  csr_pkg::csr_data_t acc_mask_i,
  input  csr_pkg::csr_data_t acc_wdata_i,
  output logic               push_valid_o,
  input  logic               push_ready_i,
  output csr_pkg::csr_data_t push_data_o,
  input  logic               excp_valid_i,
  input  csr_pkg::csr_data_t excp_pc_i,
  input  csr_pkg::ecode_t    excp_ecode_i,
  input  logic               ertn_i,
  output csr_pkg::csr_data_t crmd_o,
  output csr_pkg::csr_data_t era_o,
  output csr_pkg::csr_data_t eentry_o
);
  import csr_pkg::*;

  localparam csr_data_t CRMD_RST  = csr_data_t'(1) << `CRMD_DA; // DA set out of reset
  localparam csr_data_t EENTRY_WR = ~csr_data_t'((1 << `EENTRY_ALIGN) - 1);

  csr_data_t   crmd_q;
  csr_data_t   prmd_q;
  csr_data_t   estat_q;
  csr_data_t   era_q;
  csr_data_t   eentry_q;
  csr_data_t   save_q [4];
  csr_data_t   tid_q;
  logic [63:0] cnt_q;

  csr_data_t crmd_d;
  csr_data_t prmd_d;
  csr_data_t estat_d;
  csr_data_t era_d;
  csr_data_t old_val;
  logic      wr_en;

  function automatic csr_data_t merge(input csr_data_t old_v, input csr_data_t data,
                                      input csr_data_t mask);
    return (old_v & ~mask) | (data & mask);
  endfunction

  // Per-register write mask, zero unless this register is written
  function automatic csr_data_t wmask(input logic en, input csr_sel_t sel, input csr_sel_t hit,
                                      input csr_data_t mask, input csr_data_t limit);
    return (en && sel == hit) ? (mask & limit) : '0;
  endfunction

  assign acc_ready_o  = push_ready_i;
  assign push_valid_o = acc_valid_i;
  assign wr_en        = acc_valid_i && push_ready_i && (acc_mask_i != '0);

  // Old value goes back as the response
  always_comb begin
    old_val = '0;
    case (acc_cnt_i)
      `RDCNT_ID:    old_val = tid_q;
      `RDCNT_VLOW:  old_val = cnt_q[31:0];
      `RDCNT_VHIGH: old_val = cnt_q[63:32];
      default: begin
        case (acc_sel_i)
          SEL_CRMD:   old_val = crmd_q;
          SEL_PRMD:   old_val = prmd_q;
          SEL_ESTAT:  old_val = estat_q;
          SEL_ERA:    old_val = era_q;
          SEL_EENTRY: old_val = eentry_q;
          SEL_SAVE0:  old_val = save_q[0];
          SEL_SAVE1:  old_val = save_q[1];
          SEL_SAVE2:  old_val = save_q[2];
          SEL_SAVE3:  old_val = save_q[3];
          SEL_TID:    old_val = tid_q;
          default:    old_val = '0;
        endcase
      end
    endcase
  end

  assign push_data_o = old_val;

  always_comb begin
    crmd_d  = crmd_q;
    prmd_d  = prmd_q;
    estat_d = estat_q;
    era_d   = era_q;
    if (excp_valid_i) begin
      prmd_d[`PRMD_PPLV]    = crmd_q[`CRMD_PLV];
      prmd_d[`PRMD_PIE]     = crmd_q[`CRMD_IE];
      crmd_d[`CRMD_PLV]     = '0;
      crmd_d[`CRMD_IE]      = 1'b0;
      era_d                 = excp_pc_i;
      estat_d[`ESTAT_ECODE] = excp_ecode_i;
    end
    if (ertn_i) begin
      crmd_d[`CRMD_PLV] = prmd_q[`PRMD_PPLV];
      crmd_d[`CRMD_IE]  = prmd_q[`PRMD_PIE];
    end
    // Software write overrides events on its own fields
    crmd_d  = merge(crmd_d, acc_wdata_i,
                    wmask(wr_en, acc_sel_i, SEL_CRMD, acc_mask_i, `CRMD_WR_MASK));
    prmd_d  = merge(prmd_d, acc_wdata_i,
                    wmask(wr_en, acc_sel_i, SEL_PRMD, acc_mask_i, `PRMD_WR_MASK));
    estat_d = merge(estat_d, acc_wdata_i,
                    wmask(wr_en, acc_sel_i, SEL_ESTAT, acc_mask_i, `ESTAT_WR_MASK));
    era_d   = merge(era_d, acc_wdata_i, wmask(wr_en, acc_sel_i, SEL_ERA, acc_mask_i, '1));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q   <= CRMD_RST;
      prmd_q   <= '0;
      estat_q  <= '0;
      era_q    <= '0;
      eentry_q <= '0;
      save_q   <= '{default: '0};
      tid_q    <= '0;
      cnt_q    <= '0;
    end else begin
      crmd_q   <= crmd_d;
      prmd_q   <= prmd_d;
      estat_q  <= estat_d;
      era_q    <= era_d;
      eentry_q <= merge(eentry_q, acc_wdata_i,
                        wmask(wr_en, acc_sel_i, SEL_EENTRY, acc_mask_i, EENTRY_WR));
      tid_q    <= merge(tid_q, acc_wdata_i, wmask(wr_en, acc_sel_i, SEL_TID, acc_mask_i, '1));
      for (int i = 0; i < 4; i++) begin
        save_q[i] <= merge(save_q[i], acc_wdata_i,
                           wmask(wr_en, acc_sel_i, csr_sel_t'(SEL_SAVE0 + i), acc_mask_i, '1));
      end
      cnt_q    <= cnt_q + 64'd1; // Stable counter
    end
  end

  assign crmd_o   = crmd_q;
  assign era_o    = era_q;
  assign eentry_o = eentry_q;

  a_event_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(excp_valid_i && ertn_i)
  );

  a_crmd_upper: assert property (
    @(posedge clk) disable iff (!rst_n) (crmd_q & ~`CRMD_WR_MASK) == '0
  );

endmodule

// ==== hdl/csr_req_decode.sv ====
`include "csr_cfg.svh"

module csr_req_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  csr_pkg::csr_addr_t req_addr_i,
  input  csr_pkg::rdcnt_t    req_cnt_i,
  input  csr_pkg::csr_data_t req_mask_i,
  input  csr_pkg::csr_data_t req_wdata_i,
  output logic               acc_valid_o,
  input  logic               acc_ready_i,
  output csr_pkg::csr_sel_t  acc_sel_o,
  output csr_pkg::rdcnt_t    acc_cnt_o,
  output csr_pkg::csr_data_t acc_mask_o,
  output csr_pkg::csr_data_t acc_wdata_o
);
  import csr_pkg::*;

  csr_sel_t sel_d;
  logic     req_fire;

  // Full address compare, counter reads bypass it
  always_comb begin
    sel_d = SEL_NONE;
    if (req_cnt_i == `RDCNT_NONE) begin
      case (req_addr_i)
        `CSR_CRMD:   sel_d = SEL_CRMD;
        `CSR_PRMD:   sel_d = SEL_PRMD;
        `CSR_ESTAT:  sel_d = SEL_ESTAT;
        `CSR_ERA:    sel_d = SEL_ERA;
        `CSR_EENTRY: sel_d = SEL_EENTRY;
        `CSR_SAVE0:  sel_d = SEL_SAVE0;
        `CSR_SAVE1:  sel_d = SEL_SAVE1;
        `CSR_SAVE2:  sel_d = SEL_SAVE2;
        `CSR_SAVE3:  sel_d = SEL_SAVE3;
        `CSR_TID:    sel_d = SEL_TID;
        default:     sel_d = SEL_NONE;
      endcase
    end
  end

  assign req_ready_o = !acc_valid_o || acc_ready_i; // Empty or draining
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_valid_o <= 1'b0;
    end else if (req_fire) begin
      acc_valid_o <= 1'b1;
    end else if (acc_ready_i) begin
      acc_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      acc_sel_o   <= sel_d;
      acc_cnt_o   <= req_cnt_i;
      acc_mask_o  <= req_mask_i;
      acc_wdata_o <= req_wdata_i;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    acc_valid_o && !acc_ready_i |=>
      acc_valid_o && $stable({acc_sel_o, acc_cnt_o, acc_mask_o, acc_wdata_o})
  );

endmodule

// ==== hdl/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CSR_DATA_W-1:0] csr_data_t;
  typedef logic [`CSR_SEL_W-1:0]  csr_sel_t;
  typedef logic [1:0]             rdcnt_t;
  typedef logic [5:0]             ecode_t;

  // Internal register select, zero means no register
  localparam csr_sel_t SEL_NONE   = 4'd0;
  localparam csr_sel_t SEL_CRMD   = 4'd1;
  localparam csr_sel_t SEL_PRMD   = 4'd2;
  localparam csr_sel_t SEL_ESTAT  = 4'd3;
  localparam csr_sel_t SEL_ERA    = 4'd4;
  localparam csr_sel_t SEL_EENTRY = 4'd5;
  localparam csr_sel_t SEL_SAVE0  = 4'd6;
  localparam csr_sel_t SEL_SAVE1  = 4'd7;
  localparam csr_sel_t SEL_SAVE2  = 4'd8;
  localparam csr_sel_t SEL_SAVE3  = 4'd9;
  localparam csr_sel_t SEL_TID    = 4'd10;

endpackage

// ==== hdl/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define CSR_SEL_W  4

// CSR addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040

`define CRMD_PLV     1:0
`define CRMD_IE      2
`define CRMD_DA      3
`define PRMD_PPLV    1:0
`define PRMD_PIE     2
`define ESTAT_ECODE  21:16
`define EENTRY_ALIGN 6

// Software writable bits
`define CRMD_WR_MASK  32'h0000_01ff
`define PRMD_WR_MASK  32'h0000_0007
`define ESTAT_WR_MASK 32'h0000_0003

`define RDCNT_NONE  2'd0
`define RDCNT_ID    2'd1
`define RDCNT_VLOW  2'd2
`define RDCNT_VHIGH 2'd3

`define RSP_DEPTH 2

`endif
